// ==== glbl_reg.f ====
+incdir+include
logic/glbl_map_pkg.sv
logic/glbl_types_pkg.sv
logic/glbl_reg_file.sv
logic/glbl_rst_ctrl.sv
logic/glbl_intr_ctrl.sv
logic/glbl_reg.sv
test/tb_glbl_reg.sv

// ==== logic/glbl_intr_ctrl.sv ====
/*
 * Global interrupt controller.
 * Double-synchronizes the asynchronous sources, builds the request word,
 * and keeps mask and status. Status is write-1-to-clear at ADDR_IRQ_STAT
 * and software-set at ADDR_IRQ_SET; irq_lines is mask AND status.
 */
`timescale 1ns/1ps
`default_nettype none

module glbl_intr_ctrl
   import glbl_map_pkg::*, glbl_types_pkg::*;
(
   input  logic              mclk,
   input  logic              s_reset_n,
   input  reg_wr_t           reg_wr,
   input  intr_src_t         intr_src,
   output logic [DATA_W-1:0] irq_mask,
   output logic [DATA_W-1:0] irq_stat,
   output logic [DATA_W-1:0] irq_lines
);

   // Synchronizer order is {ir, rtc, usbh, usbd, i2cm}
   logic [4:0]        async_in;
   logic [4:0]        sync_s;
   logic [4:0]        sync_ss;
   logic [DATA_W-1:0] hw_req;
   logic [DATA_W-1:0] wr_lanes;
   logic [DATA_W-1:0] sw_set;
   logic [DATA_W-1:0] sw_clr;
   logic              mask_wr;
   logic              stat_wr;
   logic              set_wr;

   // --------------------------------------------------
   // Source synchronizers
   // --------------------------------------------------
   assign async_in = {intr_src.ir, intr_src.rtc, intr_src.usbh,
                      intr_src.usbd, intr_src.i2cm};

   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         sync_s  <= '0;
         sync_ss <= '0;
      end else begin
         sync_s  <= async_in;
         sync_ss <= sync_s;
      end
   end

   // Request word, gpio[7:0] is port A and not routed here
   // USB host and device share bit 4
   assign hw_req = {intr_src.gpio[31:8],
                    sync_ss[4],
                    sync_ss[3],
                    intr_src.pwm,
                    sync_ss[2] | sync_ss[1],
                    sync_ss[0],
                    intr_src.timer};

   // --------------------------------------------------
   // Register writes
   // --------------------------------------------------
   assign mask_wr  = reg_wr.wr_stb && (reg_wr.addr == ADDR_IRQ_MASK);
   assign stat_wr  = reg_wr.wr_stb && (reg_wr.addr == ADDR_IRQ_STAT);
   assign set_wr   = reg_wr.wr_stb && (reg_wr.addr == ADDR_IRQ_SET);

   // Write data limited to enabled lanes
   assign wr_lanes = be_merge('0, reg_wr.wdata, reg_wr.be);
   assign sw_set   = set_wr  ? wr_lanes : '0;
   assign sw_clr   = stat_wr ? wr_lanes : '0;

   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         irq_mask <= '0;
         irq_stat <= '0;
      end else begin
         if (mask_wr) begin
            irq_mask <= be_merge(irq_mask, reg_wr.wdata, reg_wr.be);
         end
         // Set beats clear in the same cycle
         irq_stat <= (irq_stat & ~sw_clr) | hw_req | sw_set;
      end
   end

   assign irq_lines = irq_mask & irq_stat;

   // A raised line always has its status bit behind it
   a_line_has_stat: assert property (@(posedge mclk) disable iff (!s_reset_n)
      (irq_lines & ~irq_stat) == '0);

endmodule

`default_nettype wire

// ==== logic/glbl_map_pkg.sv ====
/*
 * Address map and constants of the global register block.
 * Word addresses, reset values, chip ID fields and the boot strap index.
 * Imported by every module of the block and by the testbench.
 */
`default_nettype none

package glbl_map_pkg;

   // Bus widths
   localparam int ADDR_W = 5;
   localparam int DATA_W = 32;
   localparam int BE_W   = DATA_W / 8;

   // Word addresses
   localparam logic [ADDR_W-1:0] ADDR_CHIP_ID   = 5'd0;
   localparam logic [ADDR_W-1:0] ADDR_RST_CTRL  = 5'd1;
   localparam logic [ADDR_W-1:0] ADDR_CFG       = 5'd2;
   localparam logic [ADDR_W-1:0] ADDR_IRQ_MASK  = 5'd3;
   localparam logic [ADDR_W-1:0] ADDR_IRQ_STAT  = 5'd4;
   localparam logic [ADDR_W-1:0] ADDR_IRQ_SET   = 5'd10;
   localparam logic [ADDR_W-1:0] ADDR_SYS_STRAP = 5'd14;
   localparam logic [ADDR_W-1:0] ADDR_MAILBOX   = 5'd15;
   localparam logic [ADDR_W-1:0] ADDR_SW_BASE   = 5'd16;

   // Software register bank
   localparam int SW_REG_CNT = 8;
   localparam int SW_IDX_W   = $clog2(SW_REG_CNT);

   // Chip ID fields, "RD" in ASCII for the maker
   localparam logic [15:0] MANU_ID    = 16'h8268;
   localparam logic [3:0]  TOTAL_CORE = 4'd2;
   localparam logic [3:0]  CHIP_ID    = 4'd7;
   localparam logic [7:0]  CHIP_REV   = 8'h01;
   localparam logic [DATA_W-1:0] CHIP_ID_WORD = {MANU_ID, TOTAL_CORE, CHIP_ID, CHIP_REV};

   // Software register reset values, "RISC" signature, DDMMYYYY, revision 5.2
   localparam logic [DATA_W-1:0] CHIP_SIGNATURE    = 32'h8273_8343;
   localparam logic [DATA_W-1:0] CHIP_RELEASE_DATE = 32'h1808_2022;
   localparam logic [DATA_W-1:0] CHIP_REVISION     = 32'h0005_2000;
   localparam logic [SW_REG_CNT-1:0][DATA_W-1:0] SW_RST_VAL =
      {{(SW_REG_CNT-3){32'h0}}, CHIP_REVISION, CHIP_RELEASE_DATE, CHIP_SIGNATURE};

   // Reset control word, strap set releases core 0 as well
   localparam logic [DATA_W-1:0] RST_CTRL_BOOT = 32'h0000_0103;
   localparam logic [DATA_W-1:0] RST_CTRL_HOLD = 32'h0000_0003;
   localparam int STRAP_BOOT_BIT = 12;

endpackage

`default_nettype wire

// ==== logic/glbl_reg.sv ====
/*
 * Global register block of the microcontroller.
 * 32-word bank on a chip-select bus: chip ID, reset control, config,
 * interrupt mask/status/set, strap readback, mailbox and software words.
 */
`timescale 1ns/1ps
`default_nettype none

module glbl_reg
   import glbl_map_pkg::*, glbl_types_pkg::*;
(
   input  logic              mclk,
   input  logic              s_reset_n,
   input  reg_req_t          reg_req,
   input  logic [DATA_W-1:0] system_strap,
   input  intr_src_t         intr_src,
   output logic [DATA_W-1:0] reg_rdata,
   output logic              reg_ack,
   output rst_ctrl_t         rst_ctrl,
   output cfg_t              cfg,
   output logic [DATA_W-1:0] irq_lines
);

   reg_wr_t           reg_wr;
   rst_ctrl_u         rst_word;
   logic [DATA_W-1:0] irq_mask;
   logic [DATA_W-1:0] irq_stat;

   // Bus decode, read mux and local words
   glbl_reg_file u_reg_file (
      .mclk         (mclk),
      .s_reset_n    (s_reset_n),
      .reg_req      (reg_req),
      .system_strap (system_strap),
      .rst_word     (rst_word),
      .irq_mask     (irq_mask),
      .irq_stat     (irq_stat),
      .reg_wr       (reg_wr),
      .reg_rdata    (reg_rdata),
      .reg_ack      (reg_ack),
      .cfg          (cfg)
   );

   // Boot strap picks the reset value
   glbl_rst_ctrl u_rst_ctrl (
      .mclk       (mclk),
      .s_reset_n  (s_reset_n),
      .reg_wr     (reg_wr),
      .boot_strap (system_strap[STRAP_BOOT_BIT]),
      .rst_word   (rst_word)
   );

   glbl_intr_ctrl u_intr_ctrl (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .reg_wr    (reg_wr),
      .intr_src  (intr_src),
      .irq_mask  (irq_mask),
      .irq_stat  (irq_stat),
      .irq_lines (irq_lines)
   );

   // Field view out to the reset lines
   assign rst_ctrl = rst_word.f;

endmodule

`default_nettype wire

// ==== logic/glbl_reg_file.sv ====
/*
 * Bus side of the global register block.
 * Generates ack one cycle after cs, registers the read word, and holds
 * the configuration, mailbox and software registers. Writes land on the
 * edge that ends the ack cycle and go out on reg_wr to the neighbours.
 */
`timescale 1ns/1ps
`default_nettype none

module glbl_reg_file
   import glbl_map_pkg::*, glbl_types_pkg::*;
(
   input  logic              mclk,
   input  logic              s_reset_n,
   input  reg_req_t          reg_req,
   input  logic [DATA_W-1:0] system_strap,
   input  rst_ctrl_u         rst_word,
   input  logic [DATA_W-1:0] irq_mask,
   input  logic [DATA_W-1:0] irq_stat,
   output reg_wr_t           reg_wr,
   output logic [DATA_W-1:0] reg_rdata,
   output logic              reg_ack,
   output cfg_t              cfg
);

   logic                             wr_en;
   logic                             sw_hit;
   logic [SW_IDX_W-1:0]              sw_idx;
   logic [DATA_W-1:0]                rd_word;
   logic [DATA_W-1:0]                mailbox;
   logic [SW_REG_CNT-1:0][DATA_W-1:0] sw_reg;

   // --------------------------------------------------
   // Decode
   // --------------------------------------------------
   // Write only in the ack cycle so it acts exactly once
   assign wr_en  = reg_req.cs & reg_req.wr & reg_ack;

   // Software bank window
   assign sw_hit = (reg_req.addr >= ADDR_SW_BASE) &&
                   (reg_req.addr <  ADDR_SW_BASE + SW_REG_CNT);
   assign sw_idx = SW_IDX_W'(reg_req.addr - ADDR_SW_BASE);

   // Strobe to reset and interrupt control
   assign reg_wr = '{wr_stb: wr_en,
                     addr:   reg_req.addr,
                     wdata:  reg_req.wdata,
                     be:     reg_req.be};

   // --------------------------------------------------
   // Acknowledge and read data
   // --------------------------------------------------
   // One-cycle ack, held cs gives an access every other cycle
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         reg_ack <= 1'b0;
      end else begin
         reg_ack <= reg_req.cs & ~reg_ack;
      end
   end

   // Read word captured on the ack edge
   always_ff @(posedge mclk) begin
      if (reg_req.cs && !reg_ack) begin
         reg_rdata <= rd_word;
      end
   end

   // Read mux
   always_comb begin
      rd_word = '0;
      case (reg_req.addr)
         ADDR_CHIP_ID:                rd_word = CHIP_ID_WORD;
         ADDR_RST_CTRL:               rd_word = rst_word.raw;
         ADDR_CFG:                    rd_word = cfg;
         ADDR_IRQ_MASK:               rd_word = irq_mask;
         // Set address reads back as status
         ADDR_IRQ_STAT, ADDR_IRQ_SET: rd_word = irq_stat;
         ADDR_SYS_STRAP:              rd_word = system_strap;
         ADDR_MAILBOX:                rd_word = mailbox;
         default: begin
            // Unmapped words stay zero
            if (sw_hit) begin
               rd_word = sw_reg[sw_idx];
            end
         end
      endcase
   end

   // --------------------------------------------------
   // Local registers
   // --------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         cfg     <= '0;
         mailbox <= '0;
         // First three hold signature, date and revision
         sw_reg  <= SW_RST_VAL;
      end else if (wr_en) begin
         if (reg_req.addr == ADDR_CFG) begin
            cfg <= cfg_t'(be_merge(cfg, reg_req.wdata, reg_req.be));
         end
         if (reg_req.addr == ADDR_MAILBOX) begin
            mailbox <= be_merge(mailbox, reg_req.wdata, reg_req.be);
         end
         if (sw_hit) begin
            sw_reg[sw_idx] <= be_merge(sw_reg[sw_idx], reg_req.wdata, reg_req.be);
         end
      end
   end

   // Ack is a single pulse per access
   a_ack_single: assert property (@(posedge mclk) disable iff (!s_reset_n)
      reg_ack |=> !reg_ack);

endmodule

`default_nettype wire

// ==== logic/glbl_rst_ctrl.sv ====
/*
 * Reset control register.
 * Reset value comes from the boot strap, so the CPU core either starts
 * straight away or waits for software. Written by byte lane at
 * ADDR_RST_CTRL, its fields drive the block reset lines.
 */
`timescale 1ns/1ps
`default_nettype none

module glbl_rst_ctrl
   import glbl_map_pkg::*, glbl_types_pkg::*;
(
   input  logic      mclk,
   input  logic      s_reset_n,
   input  reg_wr_t   reg_wr,
   input  logic      boot_strap,
   output rst_ctrl_u rst_word
);

   logic wr_hit;

   assign wr_hit = reg_wr.wr_stb && (reg_wr.addr == ADDR_RST_CTRL);

   // Strap set releases core 0 along with cpu_intf and qspim
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         rst_word.raw <= boot_strap ? RST_CTRL_BOOT : RST_CTRL_HOLD;
      end else if (wr_hit) begin
         rst_word.raw <= be_merge(rst_word.raw, reg_wr.wdata, reg_wr.be);
      end
   end

   // Reset lines must be clean once out of reset
   a_rst_known: assert property (@(posedge mclk) disable iff (!s_reset_n)
      !$isunknown(rst_word.raw));

endmodule

`default_nettype wire

// ==== logic/glbl_types_pkg.sv ====
/*
 * Types of the global register block.
 * Register bus request, internal write strobe, reset control and
 * configuration words, interrupt sources and the byte-lane merge.
 */
`default_nettype none

package glbl_types_pkg;
   import glbl_map_pkg::*;

   // Request from the bus master, held stable while cs is high
   typedef struct packed {
      logic              cs;
      logic              wr;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [BE_W-1:0]   be;
   } reg_req_t;

   // Write strobe, high in the ack cycle of a write
   typedef struct packed {
      logic              wr_stb;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [BE_W-1:0]   be;
   } reg_wr_t;

   // Reset control word, all lines active low
   typedef struct packed {
      logic [19:0] spare;
      logic [3:0]  cpu_core;
      logic        usbd;
      logic        uart1;
      logic        usbh;
      logic        i2cm;
      logic        uart0;
      logic        sspim;
      logic        qspim;
      logic        cpu_intf;
   } rst_ctrl_t;

   // Bus view and field view of the same word
   typedef union packed {
      logic [DATA_W-1:0] raw;
      rst_ctrl_t         f;
   } rst_ctrl_u;

   // Configuration word
   typedef struct packed {
      logic [15:0] riscv_ctrl;
      logic [11:0] rsvd;
      logic        soft_irq;
      logic [2:0]  user_irq;
   } cfg_t;

   // Raw interrupt sources, usb/i2c/rtc/ir are asynchronous
   typedef struct packed {
      logic [31:0] gpio;
      logic        usbh;
      logic        usbd;
      logic        i2cm;
      logic        pwm;
      logic        rtc;
      logic        ir;
      logic [2:0]  timer;
   } intr_src_t;

   // Byte lanes of new_word where be is set, old_word elsewhere
   function automatic logic [DATA_W-1:0] be_merge(input logic [DATA_W-1:0] old_word,
                                                  input logic [DATA_W-1:0] new_word,
                                                  input logic [BE_W-1:0]   be);
      logic [DATA_W-1:0] merged;
      merged = old_word;
      for (int i = 0; i < BE_W; i++) begin
         if (be[i]) begin
            merged[8*i +: 8] = new_word[8*i +: 8];
         end
      end
      return merged;
   endfunction

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the global register block testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f glbl_reg.f --top-module tb_glbl_reg \
   -Mdir obj_dir -o sim_glbl_reg

./obj_dir/sim_glbl_reg | tee sim.log

if grep -q "Checks failed" sim.log; then
   echo "Simulation reported failures"
   exit 1
fi
echo "Simulation finished without failures"

// ==== include/glbl_tb_checks.svh ====
/*
 * Compare tasks and pass/fail counters for the global register testbench.
 * Included inside the testbench module after the package imports.
 * Each call prints one line, CHECK FAILED on a mismatch.
 */
`ifndef GLBL_TB_CHECKS_SVH
`define GLBL_TB_CHECKS_SVH

int unsigned pass_cnt = 0;
int unsigned fail_cnt = 0;

// Data word compare, the other checks funnel through here
task automatic check_word(input string             name,
                          input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] act);
   if (act === exp) begin
      pass_cnt++;
      $display("PASS         %-28s %h", name, act);
   end else begin
      fail_cnt++;
      $display("CHECK FAILED %-28s expected %h actual %h", name, exp, act);
   end
endtask

// Reset lines as a whole word
task automatic check_rst(input string name, input rst_ctrl_t exp, input rst_ctrl_t act);
   check_word(name, exp, act);
endtask

// Config output as a whole word
task automatic check_cfg(input string name, input cfg_t exp, input cfg_t act);
   check_word(name, exp, act);
endtask

task automatic check_irq(input string             name,
                         input logic [DATA_W-1:0] exp,
                         input logic [DATA_W-1:0] act);
   check_word(name, exp, act);
endtask

`endif

// ==== test/tb_glbl_reg.sv ====
/*
 * Testbench of the global register block.
 * Builds a table of bus reads, writes, interrupt pulses and output
 * checks, then applies it in one loop. Expected words follow the
 * register map and the bus and interrupt rules of the block.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_glbl_reg
   import glbl_map_pkg::*, glbl_types_pkg::*;
();

`include "glbl_tb_checks.svh"

   typedef enum logic [2:0] {OP_RD, OP_WR, OP_PULSE, OP_RST, OP_CFG, OP_IRQ} op_e;

   // One table row, be[0] doubles as the i2cm level for a pulse
   typedef struct {
      string       name;
      op_e         op;
      logic [4:0]  addr;
      logic [3:0]  be;
      logic [31:0] data;
      logic [31:0] exp;
   } step_t;

   localparam logic [31:0] STRAP = 32'h5a5a_1a5a;

   logic              mclk;
   logic              s_reset_n;
   reg_req_t          reg_req;
   logic [31:0]       system_strap;
   intr_src_t         intr_src;
   logic [31:0]       reg_rdata;
   logic              reg_ack;
   rst_ctrl_t         rst_ctrl;
   cfg_t              cfg;
   logic [31:0]       irq_lines;
   step_t             steps[$];
   integer            seed = 32'hb01a2739;
   int unsigned       cycle_cnt = 0;
   int unsigned       cycle_limit = 0;

   glbl_reg i_dut (
      .mclk         (mclk),
      .s_reset_n    (s_reset_n),
      .reg_req      (reg_req),
      .system_strap (system_strap),
      .intr_src     (intr_src),
      .reg_rdata    (reg_rdata),
      .reg_ack      (reg_ack),
      .rst_ctrl     (rst_ctrl),
      .cfg          (cfg),
      .irq_lines    (irq_lines)
   );

   // 40 ns clock
   initial begin
      mclk = 1'b0;
      forever #20 mclk = ~mclk;
   end

   // --------------------------------------------------
   // Expected-value helpers
   // --------------------------------------------------
   // Enabled byte lanes take the new word
   function automatic logic [31:0] byte_update(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  be);
      logic [31:0] m;
      m = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
      return (old_w & ~m) | (new_w & m);
   endfunction

   // Reset fields by the documented bit map
   function automatic rst_ctrl_t rst_from_bits(input logic [31:0] w);
      rst_ctrl_t r;
      r.cpu_intf = w[0];
      r.qspim    = w[1];
      r.sspim    = w[2];
      r.uart0    = w[3];
      r.i2cm     = w[4];
      r.usbh     = w[5];
      r.uart1    = w[6];
      r.usbd     = w[7];
      r.cpu_core = w[11:8];
      r.spare    = w[31:12];
      return r;
   endfunction

   function automatic cfg_t cfg_from_bits(input logic [31:0] w);
      cfg_t c;
      c.riscv_ctrl = w[31:16];
      c.rsvd       = w[15:4];
      c.soft_irq   = w[3];
      c.user_irq   = w[2:0];
      return c;
   endfunction

   task automatic add_step(input string name, input op_e op, input logic [4:0] addr,
                           input logic [3:0] be, input logic [31:0] data,
                           input logic [31:0] exp);
      step_t s;
      s.name = name;
      s.op   = op;
      s.addr = addr;
      s.be   = be;
      s.data = data;
      s.exp  = exp;
      steps.push_back(s);
   endtask

   // --------------------------------------------------
   // Stimulus table
   // --------------------------------------------------
   task automatic build_table();
      logic [31:0] rnd [0:4];
      for (int i = 0; i < 5; i++) begin
         rnd[i] = $random(seed);
      end
      // Reset values
      add_step("chip_id", OP_RD, ADDR_CHIP_ID, 4'hf, 0, 32'h8268_2701);
      add_step("rst_ctrl_reset_rd", OP_RD, ADDR_RST_CTRL, 4'hf, 0, 32'h0000_0103);
      add_step("rst_ctrl_reset_out", OP_RST, 0, 0, 0, 32'h0000_0103);
      add_step("sw0_signature", OP_RD, ADDR_SW_BASE, 4'hf, 0, 32'h8273_8343);
      add_step("sw1_release_date", OP_RD, ADDR_SW_BASE + 5'd1, 4'hf, 0, 32'h1808_2022);
      add_step("sw2_revision", OP_RD, ADDR_SW_BASE + 5'd2, 4'hf, 0, 32'h0005_2000);
      add_step("sw3_zero", OP_RD, ADDR_SW_BASE + 5'd3, 4'hf, 0, 32'h0);
      add_step("sys_strap", OP_RD, ADDR_SYS_STRAP, 4'hf, 0, STRAP);
      add_step("unmapped_5", OP_RD, 5'd5, 4'hf, 0, 32'h0);
      add_step("unmapped_24", OP_RD, 5'd24, 4'hf, 0, 32'h0);
      add_step("cfg_reset_out", OP_CFG, 0, 0, 0, 32'h0);
      add_step("irq_lines_reset", OP_IRQ, 0, 0, 0, 32'h0);
      add_step("irq_stat_reset", OP_RD, ADDR_IRQ_STAT, 4'hf, 0, 32'h0);
      // Byte-lane writes, mailbox and software bank
      add_step("mbox_wr_full", OP_WR, ADDR_MAILBOX, 4'hf, rnd[0], 0);
      add_step("mbox_rd_full", OP_RD, ADDR_MAILBOX, 4'hf, 0, rnd[0]);
      add_step("mbox_wr_0101", OP_WR, ADDR_MAILBOX, 4'b0101, rnd[1], 0);
      add_step("mbox_rd_merge", OP_RD, ADDR_MAILBOX, 4'hf, 0,
               byte_update(rnd[0], rnd[1], 4'b0101));
      add_step("sw5_wr_full", OP_WR, ADDR_SW_BASE + 5'd5, 4'hf, rnd[2], 0);
      add_step("sw5_wr_1010", OP_WR, ADDR_SW_BASE + 5'd5, 4'b1010, rnd[3], 0);
      add_step("sw5_rd_merge", OP_RD, ADDR_SW_BASE + 5'd5, 4'hf, 0,
               byte_update(rnd[2], rnd[3], 4'b1010));
      add_step("sw0_wr_0011", OP_WR, ADDR_SW_BASE, 4'b0011, rnd[4], 0);
      add_step("sw0_rd_merge", OP_RD, ADDR_SW_BASE, 4'hf, 0,
               byte_update(32'h8273_8343, rnd[4], 4'b0011));
      // Reset control and configuration outputs
      add_step("rst_wr_low", OP_WR, ADDR_RST_CTRL, 4'b0011, 32'hffff_0a5c, 0);
      add_step("rst_fields", OP_RST, 0, 0, 0, 32'h0000_0a5c);
      add_step("rst_rd", OP_RD, ADDR_RST_CTRL, 4'hf, 0, 32'h0000_0a5c);
      add_step("cfg_wr_full", OP_WR, ADDR_CFG, 4'hf, 32'hc3a5_000d, 0);
      add_step("cfg_fields", OP_CFG, 0, 0, 0, 32'hc3a5_000d);
      add_step("cfg_wr_top", OP_WR, ADDR_CFG, 4'b1000, 32'h7e00_0000, 0);
      add_step("cfg_rd", OP_RD, ADDR_CFG, 4'hf, 0, 32'h7ea5_000d);
      // Hardware interrupts, only bit 3 masked
      add_step("mask_wr", OP_WR, ADDR_IRQ_MASK, 4'hf, 32'h0000_0008, 0);
      add_step("pulse_i2cm_gpio20", OP_PULSE, 0, 4'b0001, 32'h0010_0000, 0);
      add_step("stat_after_pulse", OP_RD, ADDR_IRQ_STAT, 4'hf, 0, 32'h0010_0008);
      add_step("lines_masked", OP_IRQ, 0, 0, 0, 32'h0000_0008);
      add_step("w1c_bit3", OP_WR, ADDR_IRQ_STAT, 4'hf, 32'h0000_0008, 0);
      add_step("lines_after_w1c", OP_IRQ, 0, 0, 0, 32'h0);
      add_step("stat_after_w1c", OP_RD, ADDR_IRQ_STAT, 4'hf, 0, 32'h0010_0000);
      add_step("w1c_gpio20", OP_WR, ADDR_IRQ_STAT, 4'hf, 32'h0010_0000, 0);
      add_step("stat_clear", OP_RD, ADDR_IRQ_STAT, 4'hf, 0, 32'h0);
      // Software set, top byte lane disabled on the second write
      add_step("set_wr", OP_WR, ADDR_IRQ_SET, 4'hf, 32'h8000_0042, 0);
      add_step("set_wr_no_lane", OP_WR, ADDR_IRQ_SET, 4'b0111, 32'h0f00_0000, 0);
      add_step("stat_after_set", OP_RD, ADDR_IRQ_STAT, 4'hf, 0, 32'h8000_0042);
      add_step("set_reads_stat", OP_RD, ADDR_IRQ_SET, 4'hf, 0, 32'h8000_0042);
      add_step("mask_wr_bit31", OP_WR, ADDR_IRQ_MASK, 4'hf, 32'h8000_0000, 0);
      add_step("lines_bit31", OP_IRQ, 0, 0, 0, 32'h8000_0000);
   endtask

   // --------------------------------------------------
   // Bus and source tasks
   // --------------------------------------------------
   // Raise cs, wait for ack, drop cs on the edge that ends the ack cycle
   task automatic bus_access(input logic wr, input logic [4:0] addr, input logic [3:0] be,
                             input logic [31:0] data, output logic [31:0] rdata);
      @(posedge mclk);
      reg_req <= '{cs: 1'b1, wr: wr, addr: addr, wdata: data, be: be};
      do begin
         @(negedge mclk);
      end while (!reg_ack);
      rdata = reg_rdata;
      @(posedge mclk);
      reg_req <= '0;
   endtask

   // One-cycle pulse, then room for the two-stage synchronizer
   task automatic pulse_src(input logic [31:0] gpio, input logic i2cm);
      @(posedge mclk);
      intr_src.gpio <= gpio;
      intr_src.i2cm <= i2cm;
      @(posedge mclk);
      intr_src <= '0;
      repeat (4) @(posedge mclk);
   endtask

   // Run limit scales with the table
   always @(posedge mclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
         $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
         $display("Checks failed");
         $finish;
      end
   end

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial begin
      logic [31:0] rd_data;
      s_reset_n    <= 1'b0;
      reg_req      <= '0;
      intr_src     <= '0;
      system_strap <= STRAP;
      build_table();
      cycle_limit = steps.size() * 20 + 100;
      repeat (10) @(posedge mclk);
      s_reset_n <= 1'b1;
      foreach (steps[i]) begin
         case (steps[i].op)
            OP_RD: begin
               bus_access(1'b0, steps[i].addr, steps[i].be, 32'h0, rd_data);
               check_word(steps[i].name, steps[i].exp, rd_data);
            end
            OP_WR: bus_access(1'b1, steps[i].addr, steps[i].be, steps[i].data, rd_data);
            OP_PULSE: pulse_src(steps[i].data, steps[i].be[0]);
            OP_RST: begin
               @(negedge mclk);
               check_rst(steps[i].name, rst_from_bits(steps[i].exp), rst_ctrl);
            end
            OP_CFG: begin
               @(negedge mclk);
               check_cfg(steps[i].name, cfg_from_bits(steps[i].exp), cfg);
            end
            default: begin
               @(negedge mclk);
               check_irq(steps[i].name, steps[i].exp, irq_lines);
            end
         endcase
      end
      $display("Summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
